//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbEepromTop
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
eepromPkg.sv
eepromIfs.sv
busConditionDetect.sv
byteShifter.sv
eepromControl.sv
pageBuffer.sv
storageArray.sv
eepromTop.sv
eepromTop_properties.sv
tbEepromTop.sv

//--- busConditionDetect.sv
`timescale 1ns/1ns
`default_nettype none

module busConditionDetect (
   input  logic SCL,
   input  logic arstN,
   input  logic busClock,
   input  logic busDataIn,
   output logic busRise,
   output logic busFall,
   output logic busBit,
   output logic startSeen,
   output logic stopSeen
);

   logic [1:0] clkSync;                          // Two-stage synchronizers
   logic [1:0] dataSync;
   logic       clkPrev;                          // Last synchronized levels
   logic       dataPrev;

   always_ff @(posedge SCL or negedge arstN) begin
      if (!arstN) begin
         clkSync   <= 2'b11;                     // Idle bus lines are high
         dataSync  <= 2'b11;
         clkPrev   <= 1'b1;
         dataPrev  <= 1'b1;
         busRise   <= 1'b0;
         busFall   <= 1'b0;
         startSeen <= 1'b0;
         stopSeen  <= 1'b0;
      end else begin
         clkSync   <= {clkSync[0], busClock};
         dataSync  <= {dataSync[0], busDataIn};
         clkPrev   <= clkSync[1];
         dataPrev  <= dataSync[1];
         busRise   <= clkSync[1] && !clkPrev;
         busFall   <= !clkSync[1] && clkPrev;
         // SDA moves while SCL stays high
         startSeen <= clkSync[1] && clkPrev && dataPrev && !dataSync[1];
         stopSeen  <= clkSync[1] && clkPrev && !dataPrev && dataSync[1];
      end
   end

   assign busBit = dataPrev;                     // Aligned with the edge flags

endmodule

`default_nettype wire

//--- byteShifter.sv
`timescale 1ns/1ns
`default_nettype none

module byteShifter import eepromPkg::*; (
   input  logic SCL,
   input  logic arstN,
   input  logic busRise,
   input  logic busFall,
   input  logic busBit,
   input  logic startSeen,
   input  logic stopSeen,
   byteLinkIf.shifter link,
   output logic busDataLow
);

   logic [3:0] bitCount;                         // Slot index 0..8
   logic       clocked;                          // Rising edge seen in this slot
   logic       active;                           // Between START and STOP
   logic       sending;                          // This byte is transmitted
   logic       fallDly;                          // Slot end, one clock late
   byteT       rxShift;
   byteT       txShift;
   logic       slotEnd;

   assign slotEnd     = active && busFall && clocked;
   assign link.rxByte = rxShift;

   always_ff @(posedge SCL or negedge arstN) begin
      if (!arstN) begin
         bitCount       <= '0;
         clocked        <= 1'b0;
         active         <= 1'b0;
         sending        <= 1'b0;
         fallDly        <= 1'b0;
         busDataLow     <= 1'b0;
         link.rxDone    <= 1'b0;
         link.masterAck <= 1'b0;
      end else begin
         link.rxDone    <= 1'b0;
         link.masterAck <= 1'b0;
         fallDly        <= slotEnd;
         if (startSeen) begin
            active     <= 1'b1;
            bitCount   <= '0;
            clocked    <= 1'b0;                  // First SCL fall ends the START
            sending    <= 1'b0;
            busDataLow <= 1'b0;
         end else if (stopSeen) begin
            active     <= 1'b0;                  // Silent until next START
            bitCount   <= '0;
            clocked    <= 1'b0;
            sending    <= 1'b0;
            busDataLow <= 1'b0;
         end else if (active) begin
            if (busRise) begin
               clocked <= 1'b1;
               if (bitCount == AckSlot && sending && !busBit)
                  link.masterAck <= 1'b1;        // Master wants another byte
            end
            if (slotEnd) begin
               clocked <= 1'b0;
               if (bitCount == AckSlot) begin
                  bitCount <= '0;
                  sending  <= link.reading;
               end else begin
                  bitCount <= bitCount + 1'b1;
               end
               if (bitCount == AckSlot - 1'b1)
                  link.rxDone <= 1'b1;
            end
            if (fallDly) begin
               if (bitCount == AckSlot)
                  busDataLow <= !sending && link.ackEnable;
               else
                  busDataLow <= sending && !txShift[ByteBits-1];  // MSB first
            end
         end
      end
   end

   always_ff @(posedge SCL) begin
      if (link.txLoad)
         txShift <= link.txByte;
      else if (slotEnd && sending && bitCount != AckSlot)
         txShift <= {txShift[ByteBits-2:0], 1'b0};
      if (active && busRise && bitCount != AckSlot)
         rxShift <= {rxShift[ByteBits-2:0], busBit};
   end

endmodule

`default_nettype wire

//--- eepromControl.sv
`timescale 1ns/1ns
`default_nettype none

module eepromControl import eepromPkg::*; #(
   parameter int AddrWidth = 10,
   parameter int PageBytes = 16
) (
   input  logic                         SCL,
   input  logic                         arstN,
   input  logic                         startSeen,
   input  logic                         stopSeen,
   input  logic [2:0]                   chipSelect,
   input  logic                         writeProtect,
   byteLinkIf.control                   link,
   memPortIf.control                    mem,
   output logic                         bufWrite,
   output logic                         bufClear,
   input  logic [$clog2(PageBytes):0]   bufCount,
   output byteT                         bufData
);

   localparam int OffsetBits = $clog2(PageBytes);

   phaseT                   phase;
   byteT                    addrHigh;
   logic [AddrWidth-1:0]    pointer;             // Current address
   logic [AddrWidth-1:0]    startAddr;           // First byte of the page write
   logic [1:0]              loadPend;            // Delay until readData is valid
   logic [2*ByteBits-1:0]   fullAddr;
   logic [OffsetBits-1:0]   nextOffset;
   logic                    ctrlMatch;

   assign fullAddr   = {addrHigh, link.rxByte};
   assign nextOffset = pointer[OffsetBits-1:0] + 1'b1;
   assign ctrlMatch  = link.rxByte[7:4] == DeviceCode && link.rxByte[3:1] == chipSelect
                       && !mem.busy;             // No ack during write cycle

   assign mem.readAddr   = pointer;
   assign mem.commitAddr = startAddr;
   assign link.txByte    = mem.readData;
   assign link.txLoad    = loadPend[1];

   always_comb begin
      case (phase)
         phControlByte:                      link.ackEnable = ctrlMatch;
         phAddrHigh, phAddrLow, phWriteData: link.ackEnable = 1'b1;
         default:                            link.ackEnable = 1'b0;
      endcase
   end

   always_ff @(posedge SCL or negedge arstN) begin
      if (!arstN) begin
         phase         <= phIdle;
         pointer       <= '0;
         loadPend      <= '0;
         link.reading  <= 1'b0;
         mem.commitReq <= 1'b0;
         bufWrite      <= 1'b0;
         bufClear      <= 1'b0;
      end else begin
         mem.commitReq <= 1'b0;
         bufWrite      <= 1'b0;
         bufClear      <= 1'b0;
         loadPend      <= {loadPend[0], 1'b0};
         if (link.txLoad)
            pointer <= pointer + 1'b1;           // Reads roll over the whole array
         if (startSeen) begin
            phase        <= phControlByte;
            link.reading <= 1'b0;
         end else if (stopSeen) begin
            mem.commitReq <= phase == phWriteData && !writeProtect && bufCount != '0;
            phase         <= phIdle;
            link.reading  <= 1'b0;
         end else if (link.rxDone) begin
            case (phase)
               phControlByte: begin
                  if (!ctrlMatch) begin
                     phase <= phIgnore;
                  end else if (link.rxByte[0]) begin
                     phase        <= phReadData;
                     link.reading <= 1'b1;
                     loadPend     <= 2'b01;
                  end else begin
                     phase <= phAddrHigh;
                  end
               end
               phAddrHigh: phase <= phAddrLow;
               phAddrLow: begin
                  pointer  <= fullAddr[AddrWidth-1:0];
                  bufClear <= 1'b1;
                  phase    <= phWriteData;
               end
               phWriteData: begin
                  bufWrite <= 1'b1;
                  pointer  <= {pointer[AddrWidth-1:OffsetBits], nextOffset};
               end
               phReadData: link.reading <= 1'b0;  // Released unless master acks
               default: ;
            endcase
         end else if (link.masterAck && phase == phReadData) begin
            link.reading <= 1'b1;
            loadPend     <= 2'b01;
         end
      end
   end

   always_ff @(posedge SCL) begin
      if (link.rxDone && phase == phAddrHigh)
         addrHigh <= link.rxByte;
      if (link.rxDone && phase == phAddrLow)
         startAddr <= fullAddr[AddrWidth-1:0];
      if (link.rxDone)
         bufData <= link.rxByte;
   end

endmodule

`default_nettype wire

//--- eepromIfs.sv
`timescale 1ns/1ns
`default_nettype none

// Byte level link between the bit shifter and the control FSM
interface byteLinkIf import eepromPkg::*; ();

   byteT rxByte;                                 // Last eight received bits
   logic rxDone;                                 // Eighth bit finished
   logic masterAck;                              // Master pulled SDA low in slot 8
   logic ackEnable;                              // Acknowledge the current byte
   byteT txByte;
   logic txLoad;                                 // Load txByte into shifter
   logic reading;                                // Device owns the data bits

   modport shifter (
      output rxByte, rxDone, masterAck,
      input  ackEnable, txByte, txLoad, reading
   );

   modport control (
      input  rxByte, rxDone, masterAck,
      output ackEnable, txByte, txLoad, reading
   );

endinterface

// Array access and write-cycle request
interface memPortIf import eepromPkg::*; #(parameter int AddrWidth = 10) ();

   logic [AddrWidth-1:0] readAddr;
   logic                 commitReq;              // Start of a write cycle
   logic [AddrWidth-1:0] commitAddr;             // First address of the page write
   byteT                 readData;               // One clock after readAddr
   logic                 busy;                   // Write cycle running

   modport control (output readAddr, commitReq, commitAddr, input readData, busy);

   modport array (input readAddr, commitReq, commitAddr, output readData, busy);

endinterface

`default_nettype wire

//--- eepromPkg.sv
`default_nettype none

package eepromPkg;

   localparam int ByteBits = 8;                  // Data byte width

   typedef logic [ByteBits-1:0] byteT;

   // Upper nibble every control byte must carry
   localparam logic [3:0] DeviceCode = 4'b1010;

   localparam logic [3:0] AckSlot = 4'd8;        // Ninth bit of a byte frame

   typedef enum logic [2:0] {
      phIdle,                                    // Bus free or after STOP
      phControlByte,                             // Waiting for the control byte
      phAddrHigh,
      phAddrLow,
      phWriteData,                               // Bytes go to the page buffer
      phReadData,                                // Device shifts out array bytes
      phIgnore                                   // Not addressed until next START
   } phaseT;

endpackage

`default_nettype wire

//--- eepromTop.sv
`timescale 1ns/1ns
`default_nettype none

module eepromTop import eepromPkg::*; #(
   parameter int AddrWidth   = 10,
   parameter int PageBytes   = 16,
   parameter int WriteCycles = 2000
) (
   input  logic       SCL,
   input  logic       arstN,
   input  logic [2:0] chipSelect,
   input  logic       writeProtect,
   input  logic       busClock,
   input  logic       busDataIn,
   output logic       busDataLow                 // High pulls SDA low
);

   localparam int OffsetBits = $clog2(PageBytes);

   logic                  busRise;
   logic                  busFall;
   logic                  busBit;
   logic                  startSeen;
   logic                  stopSeen;
   logic                  bufWrite;
   logic                  bufClear;
   logic [OffsetBits:0]   bufCount;
   logic [OffsetBits-1:0] readIndex;
   byteT                  bufData;
   byteT                  readByte;

   byteLinkIf link ();
   memPortIf #(.AddrWidth(AddrWidth)) memPort ();

   busConditionDetect busConditionDetect_inst (.*);

   byteShifter byteShifter_inst (.*);

   eepromControl #(.AddrWidth(AddrWidth), .PageBytes(PageBytes)) eepromControl_inst (
      .*, .mem(memPort)
   );

   pageBuffer #(.PageBytes(PageBytes)) pageBuffer_inst (.*);

   storageArray #(
      .AddrWidth(AddrWidth), .PageBytes(PageBytes), .WriteCycles(WriteCycles)
   ) storageArray_inst (.*, .mem(memPort));

endmodule

`default_nettype wire

//--- eepromTop_properties.sv
`timescale 1ns/1ns
`default_nettype none

module eepromTopProperties (
   input logic SCL,
   input logic arstN,
   input logic startSeen,
   input logic busClockSync,                     // Synchronized bus clock level
   input logic busDataLow,
   input logic commitReq,
   input logic busy
);

   logic startedOnce;                            // START seen since reset

   always_ff @(posedge SCL or negedge arstN) begin
      if (!arstN)
         startedOnce <= 1'b0;
      else if (startSeen)
         startedOnce <= 1'b1;
   end

   quietBeforeStart: assert property (@(posedge SCL) disable iff (!arstN)
      !startedOnce |-> !busDataLow)
      else $error("device pulled the data line low before the first START");

   // A change while the bus clock is high would look like START or STOP
   changeOnLowClock: assert property (@(posedge SCL) disable iff (!arstN)
      $changed(busDataLow) |-> !busClockSync)
      else $error("device changed the data line while the bus clock was high");

   commitWhenIdle: assert property (@(posedge SCL) disable iff (!arstN)
      commitReq |-> !busy)
      else $error("write cycle requested while the previous one was running");

endmodule

bind eepromTop eepromTopProperties eepromTopProperties_inst (
   .SCL(SCL),
   .arstN(arstN),
   .startSeen(startSeen),
   .busClockSync(busConditionDetect_inst.clkPrev),
   .busDataLow(busDataLow),
   .commitReq(memPort.commitReq),
   .busy(memPort.busy)
);

`default_nettype wire

//--- pageBuffer.sv
`timescale 1ns/1ns
`default_nettype none

module pageBuffer import eepromPkg::*; #(
   parameter int PageBytes = 16
) (
   input  logic                         SCL,
   input  logic                         arstN,
   input  logic                         bufWrite,
   input  logic                         bufClear,
   input  byteT                         bufData,
   input  logic [$clog2(PageBytes)-1:0] readIndex,
   output logic [$clog2(PageBytes):0]   bufCount,
   output byteT                         readByte
);

   localparam int OffsetBits = $clog2(PageBytes);
   localparam logic [OffsetBits:0] FullCount = PageBytes[OffsetBits:0];

   byteT                  slots [PageBytes];
   logic [OffsetBits-1:0] writeIndex;            // Wraps at page size

   always_ff @(posedge SCL or negedge arstN) begin
      if (!arstN) begin
         writeIndex <= '0;
         bufCount   <= '0;
      end else if (bufClear) begin
         writeIndex <= '0;
         bufCount   <= '0;
      end else if (bufWrite) begin
         writeIndex <= writeIndex + 1'b1;
         if (bufCount != FullCount)
            bufCount <= bufCount + 1'b1;         // Saturates at one page
      end
   end

   always_ff @(posedge SCL) begin
      if (bufWrite)
         slots[writeIndex] <= bufData;
   end

   assign readByte = slots[readIndex];

endmodule

`default_nettype wire

//--- storageArray.sv
`timescale 1ns/1ns
`default_nettype none

module storageArray import eepromPkg::*; #(
   parameter int AddrWidth   = 10,
   parameter int PageBytes   = 16,
   parameter int WriteCycles = 2000
) (
   input  logic                         SCL,
   input  logic                         arstN,
   memPortIf.array                      mem,
   input  logic [$clog2(PageBytes):0]   bufCount,
   input  byteT                         readByte,
   output logic [$clog2(PageBytes)-1:0] readIndex
);

   localparam int OffsetBits = $clog2(PageBytes);
   localparam int TimerBits  = $clog2(WriteCycles + 1);
   localparam logic [TimerBits-1:0] LastCycle = TimerBits'(WriteCycles - 1);

   byteT                            memArray [2**AddrWidth];
   logic [AddrWidth-OffsetBits-1:0] pageBase;
   logic [OffsetBits-1:0]           startOffset;
   logic [OffsetBits:0]             commitCount;
   logic [OffsetBits:0]             commitIdx;   // Next buffered byte to copy
   logic [TimerBits-1:0]            cycleLeft;
   logic                            copying;

   assign copying   = mem.busy && commitIdx < commitCount;
   assign readIndex = commitIdx[OffsetBits-1:0];

   always_ff @(posedge SCL or negedge arstN) begin
      if (!arstN) begin
         mem.busy    <= 1'b0;
         cycleLeft   <= '0;
         commitIdx   <= '0;
         commitCount <= '0;
      end else if (mem.commitReq) begin
         mem.busy    <= 1'b1;
         cycleLeft   <= LastCycle;
         commitIdx   <= '0;
         commitCount <= bufCount;
      end else if (mem.busy) begin
         if (cycleLeft == '0)
            mem.busy <= 1'b0;                    // Exactly WriteCycles clocks
         else
            cycleLeft <= cycleLeft - 1'b1;
         if (copying)
            commitIdx <= commitIdx + 1'b1;
      end
   end

   always_ff @(posedge SCL) begin
      if (mem.commitReq) begin
         pageBase    <= mem.commitAddr[AddrWidth-1:OffsetBits];
         startOffset <= mem.commitAddr[OffsetBits-1:0];
      end
      // Offset wraps inside the page
      if (copying)
         memArray[{pageBase, startOffset + commitIdx[OffsetBits-1:0]}] <= readByte;
      mem.readData <= memArray[mem.readAddr];
   end

endmodule

`default_nettype wire

//--- tbEepromTop.sv
`timescale 1ns/1ns
`default_nettype none

module tbEepromTop import eepromPkg::*; ();

   localparam int AddrWidth   = 10;
   localparam int PageBytes   = 16;
   localparam int WriteCycles = 2000;
   localparam int OffsetBits  = $clog2(PageBytes);
   localparam int MemBytes    = 2**AddrWidth;
   localparam int HalfBit     = 8;               // System clocks per bus half period
   localparam int PollLimit   = 40;
   localparam logic [2:0] OwnSelect = 3'b101;
   localparam byteT CtrlWrite = {DeviceCode, OwnSelect, 1'b0};
   localparam byteT CtrlRead  = {DeviceCode, OwnSelect, 1'b1};

   logic       SCL;
   logic       arstN;
   logic [2:0] chipSelect;
   logic       writeProtect;
   logic       busClock;
   logic       masterSda;                        // Master drive where 1 releases the line
   logic       busDataIn;
   logic       busDataLow;
   byteT       refMem [MemBytes];
   integer     seed;

   function automatic logic busLine(input logic masterDrive, input logic deviceLow);
      return masterDrive && !deviceLow;          // Open-drain wired AND
   endfunction

   assign busDataIn = busLine(masterSda, busDataLow);

   eepromTop #(
      .AddrWidth(AddrWidth), .PageBytes(PageBytes), .WriteCycles(WriteCycles)
   ) eepromTop_inst (
      .SCL(SCL), .arstN(arstN), .chipSelect(chipSelect), .writeProtect(writeProtect),
      .busClock(busClock), .busDataIn(busDataIn), .busDataLow(busDataLow)
   );

   initial begin
      SCL = 1'b0;
      forever #10 SCL = ~SCL;
   end

   task automatic reportFailure(input string line);
      $display("%s", line);
      $display("TEST FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic waitClocks(input int count);
      repeat (count) @(negedge SCL);
   endtask

   task automatic expectAck(input logic acked, input logic expected, input string what);
      assert (acked === expected) else
         reportFailure($sformatf("MISMATCH busDataIn %s ack: got 0x%h expected 0x%h",
                                 what, acked, expected));
   endtask

   task automatic busStart;
      if (!busClock) begin                       // Repeated START
         waitClocks(HalfBit / 2);
         masterSda = 1'b1;
         waitClocks(HalfBit / 2);
         busClock = 1'b1;
         waitClocks(HalfBit);
      end
      masterSda = 1'b0;
      waitClocks(HalfBit);
      busClock = 1'b0;
   endtask

   task automatic busStop;
      waitClocks(HalfBit / 2);
      masterSda = 1'b0;
      waitClocks(HalfBit / 2);
      assert (busDataLow === 1'b0) else
         reportFailure("device still holds the data line low at STOP");
      busClock = 1'b1;
      waitClocks(HalfBit);
      masterSda = 1'b1;
      waitClocks(HalfBit);
   endtask

   // One bit slot with the line sampled at the end of the high phase
   task automatic bitSlot(input logic drive, output logic seen);
      waitClocks(HalfBit / 2);
      masterSda = drive;
      waitClocks(HalfBit / 2);
      busClock = 1'b1;
      waitClocks(HalfBit);
      seen = busDataIn;
      busClock = 1'b0;
   endtask

   task automatic sendByte(input byteT value, output logic acked);
      byteT shiftOut;
      logic seen;
      shiftOut = value;
      for (int i = 0; i < ByteBits; i++) begin
         bitSlot(shiftOut[ByteBits-1], seen);
         assert (seen === shiftOut[ByteBits-1]) else
            reportFailure($sformatf("MISMATCH busDataIn: got 0x%h expected 0x%h",
                                    seen, shiftOut[ByteBits-1]));
         shiftOut = shiftOut << 1;
      end
      bitSlot(1'b1, seen);
      acked = !seen;
   endtask

   task automatic receiveByte(input logic ackIt, output byteT value);
      logic seen;
      value = '0;
      for (int i = 0; i < ByteBits; i++) begin
         bitSlot(1'b1, seen);
         value = {value[ByteBits-2:0], seen};
      end
      bitSlot(!ackIt, seen);                     // Device must leave this slot to us
      assert (busDataLow === 1'b0) else
         reportFailure($sformatf("MISMATCH busDataLow in ack slot: got 0x%h expected 0x0",
                                 busDataLow));
   endtask

   // Poll until the device acknowledges a write control byte
   task automatic waitReady;
      int   polls;
      logic acked;
      polls = 0;
      acked = 1'b0;
      while (!acked) begin
         if (polls == PollLimit)
            reportFailure("device never acknowledged its address during polling");
         busStart;
         sendByte(CtrlWrite, acked);
         if (!acked)
            busStop;
         polls++;
      end
   endtask

   task automatic sendAddress(input logic [AddrWidth-1:0] addr);
      logic [15:0] wideAddr;
      logic        acked;
      wideAddr = 16'(addr);
      sendByte(wideAddr[15:8], acked);
      expectAck(acked, 1'b1, "address high");
      sendByte(wideAddr[7:0], acked);
      expectAck(acked, 1'b1, "address low");
   endtask

   task automatic writeBlock(input logic [AddrWidth-1:0] addr, input int count,
                             input logic protect);
      byteT                 data;
      logic                 acked;
      logic [AddrWidth-1:0] where;
      writeProtect = protect;
      waitReady;
      sendAddress(addr);
      for (int k = 0; k < count; k++) begin
         data = byteT'($random(seed));
         sendByte(data, acked);
         expectAck(acked, 1'b1, "write data");
         where = {addr[AddrWidth-1:OffsetBits], OffsetBits'(addr[OffsetBits-1:0] + k)};
         if (!protect)
            refMem[where] = data;                // Later bytes overwrite inside the page
      end
      busStop;
      if (!protect) begin
         busStart;                               // Write cycle still running
         sendByte(CtrlWrite, acked);
         expectAck(acked, 1'b0, "control byte during write cycle");
         busStop;
      end
      writeProtect = 1'b0;
   endtask

   task automatic readBlock(input logic [AddrWidth-1:0] addr, input int count);
      byteT                 got;
      logic                 acked;
      logic [AddrWidth-1:0] where;
      waitReady;
      sendAddress(addr);
      busStart;
      sendByte(CtrlRead, acked);
      expectAck(acked, 1'b1, "read control");
      for (int k = 0; k < count; k++) begin
         receiveByte(k != count - 1, got);
         where = addr + AddrWidth'(k);
         assert (got === refMem[where]) else
            reportFailure($sformatf("MISMATCH busDataIn byte at 0x%h: got 0x%h expected 0x%h",
                                    where, got, refMem[where]));
      end
      busStop;
   endtask

   task automatic currentRead(input logic [AddrWidth-1:0] where);
      byteT got;
      logic acked;
      busStart;
      sendByte(CtrlRead, acked);
      expectAck(acked, 1'b1, "current read control");
      receiveByte(1'b0, got);
      assert (got === refMem[where]) else
         reportFailure($sformatf("MISMATCH busDataIn current read at 0x%h: got 0x%h expected 0x%h",
                                 where, got, refMem[where]));
      busStop;
   endtask

   task automatic wrongControl(input byteT control);
      logic acked;
      busStart;
      sendByte(control, acked);
      expectAck(acked, 1'b0, "foreign control byte");
      sendByte(8'hFF, acked);                    // Line must stay released
      expectAck(acked, 1'b0, "byte after foreign control");
      busStop;
   endtask

   initial begin
      seed         = 32'h1adb_8da8;
      arstN        = 1'b0;
      chipSelect   = OwnSelect;
      writeProtect = 1'b0;
      busClock     = 1'b1;
      masterSda    = 1'b1;
      waitClocks(4);
      arstN = 1'b1;
      waitClocks(4);

      wrongControl({DeviceCode, 3'b011, 1'b0});  // Wrong chip select
      wrongControl({4'b1011, OwnSelect, 1'b0});  // Wrong device code

      writeBlock(10'h3F0, PageBytes, 1'b0);      // Full write of the last page
      readBlock(10'h3F0, PageBytes);

      writeBlock(10'h005, PageBytes + 4, 1'b0);  // Overflow wraps in page 0
      readBlock(10'h000, PageBytes);

      writeBlock(10'h3F2, 4, 1'b1);              // Protected write leaves the page alone
      readBlock(10'h3F0, PageBytes);

      readBlock(10'h3FE, 4);                     // Rolls over to address 0
      currentRead(10'h002);

      waitClocks(10);
      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire
